// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_pdp8
FILELIST  = tb.f
SIM       = obj_dir/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@if grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: logic/pdp8_control.sv
// No auto-index, no interrupts, IOT retires as a no-op; i_start is ignored while a program is running
`timescale 1ns/1ps

module pdp8_control
	import pdp8_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_start,                    // One-cycle run request
	input  word_t       i_start_pc,
	input  word_t       i_mem_rdata,                // Registered read data
	input  opr_result_t i_opr,                      // Combinational operate result
	output mem_req_t    o_mem_req,
	output word_t       o_instr,
	output word_t       o_ac,
	output logic        o_link,
	output word_t       o_pc,
	output logic        o_running,
	output logic        o_halted,
	output logic [31:0] o_instr_count
);

	cpu_state_e  state;
	logic        defer_phase;                       // Second cycle of a pointer read
	word_t       pc;
	word_t       ac;
	logic        link;
	logic [31:0] instr_count;

	word_t       ir;                                // Held instruction after decode
	word_t       ea;                                // Effective address
	word_t       mb;                                // ISZ result waiting for its store

	word_t       instr_cur;
	opcode_e     opcode;
	logic        indirect;
	word_t       ea_direct;
	word_t       pc_inc;
	word_t       pc_skip;
	logic [12:0] tad_sum;
	cpu_state_e  operand_state;                     // Where a memory reference goes next
	logic        retire;

	always_comb begin
		instr_cur = (state == S_DECODE) ? i_mem_rdata : ir; // Fresh word during decode
		opcode    = opcode_e'(instr_cur[0:2]);
		indirect  = instr_cur[3];
		if (instr_cur[4]) begin
			ea_direct = {pc[0:PAGE_W-1], instr_cur[PAGE_W +: OFFSET_W]}; // Current page
		end else begin
			ea_direct = {{PAGE_W{1'b0}}, instr_cur[PAGE_W +: OFFSET_W]}; // Page zero
		end
		pc_inc    = pc + 12'd1;
		pc_skip   = pc + 12'd2;
		tad_sum   = {1'b0, ac} + {1'b0, i_mem_rdata};
		if (opcode == OP_AND || opcode == OP_TAD || opcode == OP_ISZ) begin
			operand_state = S_READ;
		end else begin
			operand_state = S_WRITE;                    // DCA and JMS only store
		end

		// Last cycle of each instruction
		retire = ((state == S_DECODE)
				&& (opcode == OP_OPR || opcode == OP_IOT || (opcode == OP_JMP && !indirect)))
			|| (state == S_DEFER && defer_phase && opcode == OP_JMP)
			|| (state == S_EXEC && (opcode == OP_AND || opcode == OP_TAD))
			|| (state == S_WRITE);
	end

	// Memory request decoded from the state
	always_comb begin
		o_mem_req = '0;
		case (state)
			S_FETCH: begin
				o_mem_req.en   = 1'b1;
				o_mem_req.addr = pc;
			end
			S_DEFER: begin
				o_mem_req.en   = ~defer_phase;          // Pointer read in the first cycle
				o_mem_req.addr = ea;
			end
			S_READ: begin
				o_mem_req.en   = 1'b1;
				o_mem_req.addr = ea;
			end
			S_WRITE: begin
				o_mem_req.en   = 1'b1;
				o_mem_req.we   = 1'b1;
				o_mem_req.addr = ea;
				case (opcode)
					OP_DCA:  o_mem_req.wdata = ac;
					OP_JMS:  o_mem_req.wdata = pc_inc;  // Return address
					default: o_mem_req.wdata = mb;      // ISZ
				endcase
			end
			default: o_mem_req = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= S_IDLE;
			defer_phase <= 1'b0;
			pc          <= '0;
			ac          <= '0;
			link        <= 1'b0;
			instr_count <= '0;
		end else begin
			if (retire) instr_count <= instr_count + 32'd1;
			case (state)
				S_IDLE, S_HALT: begin
					if (i_start) begin
						pc          <= i_start_pc;
						ac          <= '0;
						link        <= 1'b0;
						instr_count <= '0;
						state       <= S_FETCH;
					end
				end
				S_FETCH: state <= S_DECODE;
				S_DECODE: begin
					case (opcode)
						OP_OPR: begin
							ac    <= i_opr.ac;
							link  <= i_opr.link;
							pc    <= i_opr.skip ? pc_skip : pc_inc;
							state <= i_opr.halt ? S_HALT : S_FETCH;
						end
						OP_IOT: begin
							pc    <= pc_inc;
							state <= S_FETCH;
						end
						default: begin
							if (indirect) begin
								state <= S_DEFER;
							end else if (opcode == OP_JMP) begin
								pc    <= ea_direct;
								state <= S_FETCH;
							end else begin
								state <= operand_state;
							end
						end
					endcase
				end
				S_DEFER: begin
					defer_phase <= ~defer_phase;
					if (defer_phase) begin
						if (opcode == OP_JMP) begin
							pc    <= i_mem_rdata;           // Jump through pointer
							state <= S_FETCH;
						end else begin
							state <= operand_state;
						end
					end
				end
				S_READ: state <= S_EXEC;
				S_EXEC: begin
					case (opcode)
						OP_AND: begin
							ac    <= ac & i_mem_rdata;
							pc    <= pc_inc;
							state <= S_FETCH;
						end
						OP_TAD: begin
							ac    <= tad_sum[11:0];
							link  <= link ^ tad_sum[12];    // Carry complements link
							pc    <= pc_inc;
							state <= S_FETCH;
						end
						default: state <= S_WRITE;      // ISZ stores its increment
					endcase
				end
				S_WRITE: begin
					case (opcode)
						OP_DCA: begin
							ac <= '0;
							pc <= pc_inc;
						end
						OP_JMS: pc <= ea + 12'd1;       // Body starts after the link word
						default: pc <= (mb == '0) ? pc_skip : pc_inc;
					endcase
					state <= S_FETCH;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Instruction, address and ISZ value, no reset needed
	always_ff @(posedge i_clk) begin
		if (state == S_DECODE) begin
			ir <= i_mem_rdata;
			ea <= ea_direct;
		end
		if (state == S_DEFER && defer_phase) begin
			ea <= i_mem_rdata;                          // Pointer becomes the address
		end
		if (state == S_EXEC) begin
			mb <= i_mem_rdata + 12'd1;
		end
	end

	assign o_instr       = instr_cur;
	assign o_ac          = ac;
	assign o_link        = link;
	assign o_pc          = pc;
	assign o_running     = (state != S_IDLE) && (state != S_HALT);
	assign o_halted      = (state == S_HALT);
	assign o_instr_count = instr_count;

	a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$isunknown(state) && (state inside {S_IDLE, S_FETCH, S_DECODE, S_DEFER,
			S_READ, S_EXEC, S_WRITE, S_HALT}))
		else $error("control state is not a legal value");

	// A store during fetch would corrupt the next instruction
	a_no_fetch_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state == S_FETCH) |-> !(o_mem_req.en && o_mem_req.we))
		else $error("write request issued in fetch");

endmodule

// File: logic/pdp8_core_mem.sv
// Single-field 4096-word RAM with registered reads; host loads are only legal while the processor is stopped
`timescale 1ns/1ps

module pdp8_core_mem
	import pdp8_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  mem_req_t i_req,                         // Processor port
	input  logic     i_load_en,                     // Host write strobe
	input  word_t    i_load_addr,
	input  word_t    i_load_data,
	input  word_t    i_peek_addr,                   // Host read address, sampled each clock
	output word_t    o_cpu_rdata,
	output word_t    o_peek_data
);

	word_t mem [0:MEM_WORDS-1];                     // Core array

	logic  wr_en;
	word_t wr_addr;
	word_t wr_data;

	// One write port shared by the host loader and the processor
	always_comb begin
		wr_en   = i_load_en | (i_req.en & i_req.we);
		wr_addr = i_load_en ? i_load_addr : i_req.addr; // Host wins, they never overlap
		wr_data = i_load_en ? i_load_data : i_req.wdata;
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		if (i_req.en && !i_req.we) begin
			o_cpu_rdata <= mem[i_req.addr];             // Data valid the cycle after the request
		end
		o_peek_data <= mem[i_peek_addr];                // Free-running monitor read
	end

	// Loader and processor must never store in the same cycle
	a_no_write_clash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_load_en && i_req.en && i_req.we))
		else $error("host load collides with processor write");

endmodule

// File: logic/pdp8_operate.sv
// Group 1 and group 2 only; group 3 words (bit 3 and bit 11 set) act as no-ops, BSW is not decoded
`timescale 1ns/1ps

module pdp8_operate
	import pdp8_pkg::*;
(
	input  word_t       i_instr,                    // Current instruction word
	input  word_t       i_ac,
	input  logic        i_link,
	input  word_t       i_switches,                 // Front panel switch register
	output opr_result_t o_result
);

	logic [0:12] lac;                               // Link in bit 0, AC in bits 1..12
	word_t       ac;
	logic        link;
	logic        cond;                              // Any selected OR-group condition true
	logic        skip;
	logic        halt;

	always_comb begin
		ac   = i_ac;
		link = i_link;
		skip = 1'b0;
		halt = 1'b0;
		lac  = '0;
		cond = 1'b0;

		if (!i_instr[3]) begin
			// Group 1, sequence 1 clears
			if (i_instr[4]) ac = '0;                    // CLA
			if (i_instr[5]) link = 1'b0;                // CLL

			// Sequence 2 complements
			if (i_instr[6]) ac = ~ac;                   // CMA
			if (i_instr[7]) link = ~link;               // CML

			// Sequence 3, carry out of AC flips the link
			if (i_instr[11]) begin
				{link, ac} = {link, ac} + 13'd1;        // IAC
			end

			// Sequence 4 rotates the 13-bit link:AC
			lac = {link, ac};
			if (i_instr[8]) begin
				if (i_instr[10]) lac = {lac[11:12], lac[0:10]}; // RTR
				else lac = {lac[12], lac[0:11]};        // RAR
			end else if (i_instr[9]) begin
				if (i_instr[10]) lac = {lac[2:12], lac[0:1]};   // RTL
				else lac = {lac[1:12], lac[0]};         // RAL
			end
			link = lac[0];
			ac   = lac[1:12];
		end else if (!i_instr[11]) begin
			// Group 2, tests use the AC and link as they arrive
			cond = (i_instr[5] & i_ac[0])               // SMA, sign bit set
				| (i_instr[6] & (i_ac == '0))           // SZA
				| (i_instr[7] & i_link);                // SNL

			// Bit 8 inverts the sense, so SPA SNA SZL skip only if every one holds
			skip = i_instr[8] ? ~cond : cond;           // SKP is bit 8 with nothing selected

			if (i_instr[4]) ac = '0;                    // CLA after the test
			if (i_instr[9]) ac = ac | i_switches;       // OSR
			halt = i_instr[10];                         // HLT last
		end

		o_result.ac   = ac;
		o_result.link = link;
		o_result.skip = skip;
		o_result.halt = halt;
	end

endmodule

// File: logic/pdp8_pkg.sv
// Bit 0 is the most significant bit of every word, as in PDP-8 manuals; 4096-word field only, no extended memory
package pdp8_pkg;

	localparam int MEM_WORDS = 4096;                // One 4K field
	localparam int PAGE_W    = 5;                   // Page number bits 0..4
	localparam int OFFSET_W  = 7;                   // Word-in-page bits 5..11

	typedef logic [0:11] word_t;                    // PDP-8 bit order, MSB is bit 0

	// Major opcode in instruction bits 0..2
	typedef enum logic [2:0] {
		OP_AND = 3'd0,                              // AC <- AC & M
		OP_TAD = 3'd1,                              // Two's complement add, carry flips link
		OP_ISZ = 3'd2,                              // Increment memory, skip on zero
		OP_DCA = 3'd3,                              // Deposit AC and clear
		OP_JMS = 3'd4,                              // Subroutine call
		OP_JMP = 3'd5,                              // Jump
		OP_IOT = 3'd6,                              // No devices fitted
		OP_OPR = 3'd7                               // Microcoded operate
	} opcode_e;

	typedef enum logic [2:0] {
		S_IDLE,                                     // Waiting for a start pulse
		S_FETCH,                                    // Read request at PC
		S_DECODE,                                   // Instruction word arrives
		S_DEFER,                                    // Pointer read, two cycles
		S_READ,                                     // Operand read request
		S_EXEC,                                     // Operand arrives
		S_WRITE,                                    // Store to effective address
		S_HALT                                      // Stopped by HLT
	} cpu_state_e;

	// Processor side memory request, 26 bits
	typedef struct packed {
		logic  en;                                  // Access this cycle
		logic  we;                                  // Write when set, else read
		word_t addr;
		word_t wdata;
	} mem_req_t;

	// Operate unit answer, 15 bits
	typedef struct packed {
		word_t ac;                                  // New accumulator
		logic  link;                                // New link
		logic  skip;                                // Step PC over the next word
		logic  halt;                                // HLT seen
	} opr_result_t;

endpackage

// File: logic/pdp8_top.sv
// Host must load memory only while o_running is low; o_peek_data lags i_peek_addr by one clock
`timescale 1ns/1ps

module pdp8_top
	import pdp8_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_start,                    // Run pulse
	input  word_t       i_start_pc,
	input  word_t       i_switches,                 // OSR source
	input  logic        i_load_en,
	input  word_t       i_load_addr,
	input  word_t       i_load_data,
	input  word_t       i_peek_addr,
	output word_t       o_peek_data,
	output word_t       o_ac,
	output logic        o_link,
	output word_t       o_pc,
	output logic        o_running,
	output logic        o_halted,                   // Rises when HLT retires
	output logic [31:0] o_instr_count
);

	mem_req_t    mem_req;                           // Control to memory
	word_t       cpu_rdata;
	word_t       instr;                             // Word under execution
	opr_result_t opr;

	pdp8_control u_control (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_start),
		.i_start_pc    (i_start_pc),
		.i_mem_rdata   (cpu_rdata),
		.i_opr         (opr),
		.o_mem_req     (mem_req),
		.o_instr       (instr),
		.o_ac          (o_ac),
		.o_link        (o_link),
		.o_pc          (o_pc),
		.o_running     (o_running),
		.o_halted      (o_halted),
		.o_instr_count (o_instr_count)
	);

	pdp8_operate u_operate (
		.i_instr    (instr),
		.i_ac       (o_ac),                         // Live AC and link feed the microcode
		.i_link     (o_link),
		.i_switches (i_switches),
		.o_result   (opr)
	);

	pdp8_core_mem u_mem (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_req       (mem_req),
		.i_load_en   (i_load_en),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_peek_addr (i_peek_addr),
		.o_cpu_rdata (cpu_rdata),
		.o_peek_data (o_peek_data)
	);

endmodule

// File: tb.f
logic/pdp8_pkg.sv
logic/pdp8_core_mem.sv
logic/pdp8_operate.sv
logic/pdp8_control.sv
logic/pdp8_top.sv
tb/tb_pdp8.sv

// File: tb/tb_pdp8.sv
// Needs the RTL in logic/; programs live in pages 0 to 5 and a run must halt within 2000 cycles
`timescale 1ns/1ps

module tb_pdp8
	import pdp8_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic        start;
	word_t       start_pc;
	word_t       switches;
	logic        load_en;
	word_t       load_addr;
	word_t       load_data;
	word_t       peek_addr;
	word_t       peek_data;
	word_t       ac;
	logic        link;
	word_t       pc;
	logic        running;
	logic        halted;
	logic [31:0] instr_count;

	word_t       prog [$];                          // Words for the next load
	logic [31:0] rng_state;

	pdp8_top u_dut (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_start       (start),
		.i_start_pc    (start_pc),
		.i_switches    (switches),
		.i_load_en     (load_en),
		.i_load_addr   (load_addr),
		.i_load_data   (load_data),
		.i_peek_addr   (peek_addr),
		.o_peek_data   (peek_data),
		.o_ac          (ac),
		.o_link        (link),
		.o_pc          (pc),
		.o_running     (running),
		.o_halted      (halted),
		.o_instr_count (instr_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                      // 8 ns period
	end

	function automatic word_t rand_word();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[27:16];                    // Upper bits, better period
	endfunction

	// Link in bit 12, AC below; steps follow the group 1 sequence
	function automatic logic [12:0] group1_model(input logic [11:0] instr,
		input logic [11:0] ac_in, input logic link_in);
		logic [12:0] lac;
		int          turns;
		lac = {link_in, ac_in};
		if (instr[7]) lac[11:0] = '0;               // CLA 0200
		if (instr[6]) lac[12] = 1'b0;               // CLL 0100
		if (instr[5]) lac[11:0] = ~lac[11:0];       // CMA 0040
		if (instr[4]) lac[12] = ~lac[12];           // CML 0020
		if (instr[0]) lac = lac + 13'd1;            // IAC 0001
		turns = instr[1] ? 2 : 1;                   // 0002 doubles the rotate
		for (int i = 0; i < turns; i++) begin
			if (instr[3]) lac = {lac[0], lac[12:1]};            // RAR 0010
			else if (instr[2]) lac = {lac[11:0], lac[12]};      // RAL 0004
		end
		return lac;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %0o expected %0o", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_program(input word_t base);
		foreach (prog[i]) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= base + 12'(i);
			load_data <= prog[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		prog.delete();
	endtask

	task automatic peek(input word_t addr, output word_t data);
		@(posedge clk);
		peek_addr <= addr;
		@(posedge clk);                             // Memory samples the address here
		@(negedge clk);
		data = peek_data;
	endtask

	task automatic run_from(input word_t addr);
		int cycles;
		cycles = 0;
		@(posedge clk);
		start    <= 1'b1;
		start_pc <= addr;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		check_equal(32'(running), 32'd1, "running after start");
		while (!halted) begin
			if (cycles > 2000) begin
				$display("Processor started at %0o did not halt within 2000 cycles", addr);
				$display("TEST RESULT: FAIL");
				$fatal(1, "run timeout");
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// TAD V, optional CML, two operate words, HLT, all in page 4
	task automatic run_operate_prog(input word_t v, input logic l, input word_t op1,
		input word_t op2);
		prog.push_back(12'o1220);                   // TAD 1020
		prog.push_back(l ? 12'o7020 : 12'o7000);    // CML or NOP
		prog.push_back(op1);
		prog.push_back(op2);
		prog.push_back(12'o7402);                   // HLT
		load_program(12'o1000);
		prog.push_back(v);
		load_program(12'o1020);
		run_from(12'o1000);
	endtask

	task automatic test_arith_store();
		word_t       a;
		word_t       b;
		word_t       m;
		word_t       got;
		logic [12:0] sum;
		int          n;
		for (n = 0; n < 4; n++) begin
			a   = rand_word();
			b   = rand_word();
			m   = rand_word();
			sum = {1'b0, a} + {1'b0, b};
			prog.push_back(12'o1220);               // TAD 0620
			prog.push_back(12'o1221);               // TAD 0621
			prog.push_back(12'o0050);               // AND 0050, page zero mask
			prog.push_back(12'o3451);               // DCA I 0051
			prog.push_back(12'o7402);
			load_program(12'o0600);
			prog.push_back(a);
			prog.push_back(b);
			prog.push_back(12'o0000);
			prog.push_back(~(sum[11:0] & m));       // Stale result, must be overwritten
			load_program(12'o0620);
			prog.push_back(m);
			prog.push_back(12'o0623);               // Pointer for the deposit
			load_program(12'o0050);
			run_from(12'o0600);
			peek(12'o0623, got);
			check_equal(32'(got), 32'(sum[11:0] & m), "masked sum stored by DCA I");
			check_equal(32'(ac), 32'd0, "AC after DCA");
			check_equal(32'(link), 32'(sum[12]), "link after carry");
		end
	endtask

	task automatic test_count_loop();
		int    n;
		int    rep;
		word_t got;
		for (rep = 0; rep < 2; rep++) begin
			n = int'(rand_word() % 12'd20) + 1;
			prog.push_back(12'o1221);               // TAD 0221, minus N
			prog.push_back(12'o3220);               // DCA 0220
			prog.push_back(12'o2220);               // ISZ 0220
			prog.push_back(12'o5202);               // JMP 0202
			prog.push_back(12'o7402);
			load_program(12'o0200);
			prog.push_back(12'o1234);
			prog.push_back(12'(-n));
			load_program(12'o0220);
			run_from(12'o0200);
			peek(12'o0220, got);
			check_equal(32'(got), 32'd0, "ISZ counter at end");
			// Setup 2, N-1 passes of ISZ and JMP, last ISZ, HLT
			check_equal(instr_count, 32'(2 + 2 * (n - 1) + 1 + 1), "loop instruction count");
			check_equal(32'(pc), 32'o0205, "PC after loop");
		end
	endtask

	task automatic test_subroutine();
		word_t marker;
		word_t got;
		marker = rand_word();
		prog.push_back(12'o4210);                   // JMS 0410
		prog.push_back(12'o1220);                   // TAD 0420
		prog.push_back(12'o3221);                   // DCA 0421
		prog.push_back(12'o7402);
		load_program(12'o0400);
		prog.push_back(12'o0000);                   // Return link word
		prog.push_back(12'o5610);                   // JMP I 0410
		load_program(12'o0410);
		prog.push_back(marker);
		prog.push_back(~marker);
		load_program(12'o0420);
		run_from(12'o0400);
		peek(12'o0410, got);
		check_equal(32'(got), 32'o0401, "JMS return address");
		peek(12'o0421, got);
		check_equal(32'(got), 32'(marker), "marker deposited after return");
		check_equal(32'(pc), 32'o0404, "PC after HLT");
		check_equal(instr_count, 32'd5, "subroutine instruction count");
	endtask

	task automatic test_group1();
		word_t       ops [5];
		word_t       v;
		logic        l;
		logic [12:0] exp;
		int          k;
		int          rep;
		ops[0] = 12'o7041;                          // CMA IAC
		ops[1] = 12'o7004;                          // RAL
		ops[2] = 12'o7012;                          // RTR
		ops[3] = 12'o7120;                          // CLL CML
		ops[4] = 12'o7200;                          // CLA
		for (k = 0; k < 5; k++) begin
			for (rep = 0; rep < 2; rep++) begin
				v   = rand_word();
				l   = rand_word() > 12'o3777;
				exp = group1_model(ops[k], v, l);
				run_operate_prog(v, l, ops[k], 12'o7000);
				check_equal(32'(ac), 32'(exp[11:0]), $sformatf("AC after %04o on %04o", ops[k], v));
				check_equal(32'(link), 32'(exp[12]), $sformatf("link after %04o", ops[k]));
			end
		end
	endtask

	task automatic test_group2();
		word_t vals [3];
		word_t v;
		word_t instr;
		word_t sw;
		word_t exp_ac;
		logic  cond;
		logic  skip;
		int    vi;
		int    l;
		int    sel;
		int    rev;
		vals[0] = 12'o0000;
		vals[1] = rand_word() | 12'o4000;           // Negative
		vals[2] = (rand_word() & 12'o3777) | 12'o0001; // Positive, nonzero
		for (vi = 0; vi < 3; vi++) begin
			for (l = 0; l < 2; l++) begin
				for (sel = 0; sel < 8; sel++) begin
					for (rev = 0; rev < 2; rev++) begin
						v      = vals[vi];
						instr  = 12'o7400 | (12'(sel) << 4) | (12'(rev) << 3);
						cond   = (sel[2] & v[0]) | (sel[1] & (v == 12'o0000)) | (sel[0] & l[0]);
						skip   = rev[0] ? !cond : cond; // Bit 8 asks for none of them
						exp_ac = skip ? v : v + 12'd1;  // IAC wraps within the word
						run_operate_prog(v, l[0], instr, 12'o7001); // IAC marks no skip
						check_equal(32'(ac), 32'(exp_ac),
							$sformatf("skip %04o with AC %04o link %0d", instr, v, l));
					end
				end
			end
		end
		sw = rand_word();
		@(posedge clk);
		switches <= sw;
		v = rand_word();
		run_operate_prog(v, 1'b0, 12'o7404, 12'o7000); // OSR
		check_equal(32'(ac), 32'(v | sw), "OSR ORs switches into AC");
		run_operate_prog(v, 1'b0, 12'o7604, 12'o7000); // CLA OSR
		check_equal(32'(ac), 32'(sw), "CLA OSR");
	endtask

	initial begin
		rng_state = 32'd37752;
		rst_n     <= 1'b0;
		start     <= 1'b0;
		start_pc  <= '0;
		switches  <= '0;
		load_en   <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		peek_addr <= '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_equal(32'(running), 32'd0, "running after reset");
		check_equal(32'(halted), 32'd0, "halted after reset");
		check_equal(instr_count, 32'd0, "count after reset");
		check_equal(32'(pc), 32'd0, "PC after reset");
		check_equal(32'(ac), 32'd0, "AC after reset");
		check_equal(32'(link), 32'd0, "link after reset");
		test_arith_store();
		test_count_loop();
		test_subroutine();
		test_group1();
		test_group2();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
